// ==== sim.f ====
+incdir+.
tl_pkg.sv
mem_pkg.sv
tl_fifo.sv
byte_mem.sv
tl_access_unit.sv
tl_ul_slave_top.sv
tb_tl_ul_slave.sv

// ==== tb_tl_tests.svh ====
// Directed TL-UL tests
`ifndef TB_TL_TESTS_SVH
`define TB_TL_TESTS_SVH

// Spread over the window, both ends included
int unsigned test_words [6] = '{0, 1, 7, 100, 311, 511};

task automatic test_reset();
	cur_test = "test_reset";
	check_val("a_ready", 1, a_ready);
	check_val("d_valid", 0, d_valid);
	transact(make_req(OP_GET, MEM_BASE_ADDR, 8'hff, '0, 3'd0)); // Reads zero
endtask

task automatic test_put_full_get();
	a_req_t beat;
	cur_test = "test_put_full_get";
	foreach (test_words[i]) begin
		beat = make_req(OP_PUT_FULL, word_addr(test_words[i]), 8'hff,
			{$urandom, $urandom}, 3'($urandom));
		transact(beat);                     // AccessAck, no data
	end
	// Read back every word
	foreach (test_words[i])
		transact(make_req(OP_GET, word_addr(test_words[i]), 8'hff, '0, 3'($urandom)));
endtask

task automatic test_put_partial();
	a_req_t beat;
	cur_test = "test_put_partial";
	foreach (test_words[i]) begin
		beat = make_req(OP_PUT_PARTIAL, word_addr(test_words[i]), 8'($urandom),
			{$urandom, $urandom}, 3'($urandom));
		transact(beat);
	end
	foreach (test_words[i])
		transact(make_req(OP_GET, word_addr(test_words[i]), 8'hff, '0, 3'($urandom)));
endtask

task automatic test_errors();
	cur_test = "test_errors";
	// First byte past the window
	transact(make_req(OP_PUT_FULL, MEM_BASE_ADDR + MEM_DEPTH * 8, 8'hff,
		{$urandom, $urandom}, 3'd1));
	// Unsupported opcodes aimed at live words
	transact(make_req(OP_ARITH, word_addr(0), 8'hff, {$urandom, $urandom}, 3'd2));
	transact(make_req(OP_LOGIC, word_addr(1), 8'hff, {$urandom, $urandom}, 3'd3));
	transact(make_req(OP_INTENT, word_addr(7), 8'hff, '0, 3'd4));
	// Just below base
	transact(make_req(OP_GET, MEM_BASE_ADDR - 8, 8'hff, '0, 3'd5));
	// Targets unchanged
	transact(make_req(OP_GET, word_addr(0), 8'hff, '0, 3'd6));
	transact(make_req(OP_GET, word_addr(1), 8'hff, '0, 3'd7));
	transact(make_req(OP_GET, word_addr(7), 8'hff, '0, 3'd0));
endtask

task automatic test_backpressure();
	d_rsp_t      pending [$];             // Expected beats, issue order
	a_req_t      beat;
	logic [2:0]  op;
	int unsigned w;
	int          n;
	cur_test = "test_backpressure";
	d_ready  = 1'b0;
	n        = 0;
	while (a_ready) begin
		if (n == 8) begin                   // Sources would repeat past here
			$display("Timeout in %s: a_ready never dropped with d_ready low", cur_test);
			abort_run();
		end
		case (n % 4)
			0:       op = OP_PUT_FULL;
			1:       op = OP_PUT_PARTIAL;
			default: op = OP_GET;
		endcase
		w    = (n % 4 == 3) ? 21 : 20;      // Gets see queued writes
		beat = make_req(op, word_addr(w), 8'($urandom), {$urandom, $urandom}, 3'(n));
		pending.push_back(predict(beat));
		send_a(beat);
		n++;
	end
	// Release the D side and drain
	while (pending.size() > 0)
		expect_d(pending.pop_front());
	check_val("d_valid after drain", 0, d_valid);
endtask

`endif

// ==== tb_tl_ul_slave.sv ====
// TL-UL slave testbench
module tb_tl_ul_slave
	import tl_pkg::*;
	import mem_pkg::*;
();

	localparam int          WAIT_LIMIT = 200;           // Cycles per wait loop
	localparam logic [31:0] SEED       = 32'hef76_f9d7;

	logic   clk;
	logic   rst;
	logic   a_valid;
	logic   a_ready;
	a_req_t a_req;
	logic   d_valid;
	logic   d_ready;
	d_rsp_t d_rsp;

	logic [TL_DATA_W-1:0] ref_mem [MEM_DEPTH]; // Expected memory contents
	string                cur_test;

	tl_ul_slave_top dut0 (
		.clk     (clk),
		.rst     (rst),
		.a_valid (a_valid),
		.a_ready (a_ready),
		.a_req   (a_req),
		.d_valid (d_valid),
		.d_ready (d_ready),
		.d_rsp   (d_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // Period 8
	end

	////////////////////////////////////////////////////////////
	// Error handling and checks
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_val(input string field, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp)
		else begin
			$display("FAILED %s %s: expected %0h, actual %0h", cur_test, field, exp, act);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] word_addr(input int unsigned w);
		return MEM_BASE_ADDR + 32'(w * 8);
	endfunction

	function automatic a_req_t make_req(input logic [2:0] op, input logic [31:0] addr,
		input logic [7:0] mask, input logic [63:0] data, input logic [2:0] src);
		a_req_t r;
		r         = '0;                    // param stays reserved
		r.opcode  = op;
		r.address = addr;
		r.size    = TL_SIZE_W'(TL_WORD_SIZE); // One full beat
		r.mask    = mask;
		r.data    = data;
		r.source  = src;
		return r;
	endfunction

	// Expected D beat; applies writes to ref_mem in issue order
	function automatic d_rsp_t predict(input a_req_t r);
		d_rsp_t      e;
		logic        hit;
		int unsigned w;
		e   = '0;
		hit = (r.address >= MEM_BASE_ADDR) && (r.address < MEM_BASE_ADDR + MEM_DEPTH * 8);
		w   = (r.address - MEM_BASE_ADDR) / 8;  // Byte offset bits ignored
		e.opcode = (r.opcode == OP_GET) ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK;
		e.size   = r.size;
		e.source = r.source;
		if (r.opcode == OP_PUT_FULL || r.opcode == OP_PUT_PARTIAL || r.opcode == OP_GET)
			e.error = !hit;
		else
			e.error = 1'b1;                     // Atomics, hints
		if (!e.error) begin
			if (r.opcode == OP_GET)
				e.data = ref_mem[w];
			else
				for (int b = 0; b < 8; b++)
					if (r.opcode == OP_PUT_FULL || r.mask[b])
						ref_mem[w][8*b +: 8] = r.data[8*b +: 8]; // Byte merge
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// Channel drivers, entered and left 1 unit after an edge
	////////////////////////////////////////////////////////////

	task automatic send_a(input a_req_t beat);
		int waited;
		waited  = 0;
		a_valid = 1'b1;
		a_req   = beat;
		while (!a_ready) begin              // Hold beat until slave accepts
			if (waited == WAIT_LIMIT) begin
				$display("Timeout in %s: a_ready stayed low", cur_test);
				abort_run();
			end
			@(posedge clk);
			#1;
			waited++;
		end
		@(posedge clk);                     // Transfer edge
		#1;
		a_valid = 1'b0;
	endtask

	task automatic expect_d(input d_rsp_t exp);
		int waited;
		waited = 0;
		while (!d_valid) begin
			if (waited == WAIT_LIMIT) begin
				$display("Timeout in %s: no D response arrived", cur_test);
				abort_run();
			end
			@(posedge clk);
			#1;
			waited++;
		end
		check_val("opcode", exp.opcode, d_rsp.opcode);
		check_val("param", exp.param, d_rsp.param);
		check_val("sink", exp.sink, d_rsp.sink);
		check_val("source", exp.source, d_rsp.source);
		check_val("size", exp.size, d_rsp.size);
		check_val("data", exp.data, d_rsp.data);
		check_val("error", exp.error, d_rsp.error);
		d_ready = 1'b1;                     // Take the beat
		@(posedge clk);
		#1;
		d_ready = 1'b0;
	endtask

	task automatic transact(input a_req_t beat);
		d_rsp_t exp;
		exp = predict(beat);
		send_a(beat);
		expect_d(exp);
	endtask

	`include "tb_tl_tests.svh"

	initial begin
		void'($urandom(SEED));
		rst      = 1'b1;
		a_valid  = 1'b0;
		a_req    = '0;
		d_ready  = 1'b0;
		cur_test = "reset";
		for (int i = 0; i < MEM_DEPTH; i++)
			ref_mem[i] = '0;                // Memory clears on reset
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset();
		test_put_full_get();
		test_put_partial();
		test_errors();
		test_backpressure();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== tl_ul_slave_top.sv ====
// TL-UL memory slave top
module tl_ul_slave_top
	import tl_pkg::*;
(
	input  logic   clk,
	input  logic   rst,

	// A channel from the master
	input  logic   a_valid,
	output logic   a_ready,
	input  a_req_t a_req,

	// D channel to the master
	output logic   d_valid,
	input  logic   d_ready,
	output d_rsp_t d_rsp
);

	////////////////////////////////////////////////////////////
	// Internal links
	////////////////////////////////////////////////////////////

	logic   req_valid;  // Request FIFO head
	logic   req_ready;
	a_req_t req_data;

	logic   rsp_valid;  // Access unit output
	logic   rsp_ready;
	d_rsp_t rsp_data;

	// Request queue
	tl_fifo #(.payload_t(a_req_t)) req_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (a_valid),
		.in_ready  (a_ready),
		.in_data   (a_req),
		.out_valid (req_valid),
		.out_ready (req_ready),
		.out_data  (req_data)
	);

	tl_access_unit access0 (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp_data)
	);

	// Response queue, keeps request order
	tl_fifo #(.payload_t(d_rsp_t)) rsp_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (rsp_valid),
		.in_ready  (rsp_ready),
		.in_data   (rsp_data),
		.out_valid (d_valid),
		.out_ready (d_ready),
		.out_data  (d_rsp)
	);

endmodule

// ==== tl_access_unit.sv ====
// TL-UL request decode and memory access
module tl_access_unit
	import tl_pkg::*;
	import mem_pkg::*;
(
	input  logic   clk,
	input  logic   rst,

	// Requests from the A-side FIFO
	input  logic   req_valid,
	output logic   req_ready,
	input  a_req_t req,

	// Responses toward the D-side FIFO
	output logic   rsp_valid,
	input  logic   rsp_ready,
	output d_rsp_t rsp
);

	// Size of the window in bytes
	localparam logic [TL_ADDR_W-1:0] WIN_BYTES = TL_ADDR_W'(MEM_DEPTH) << TL_WORD_SIZE;

	logic [TL_ADDR_W-1:0] offset;
	logic                 in_range;
	mem_idx_t             idx;
	logic                 op_ok;     // Opcode supported here
	logic                 is_write;
	logic                 is_get;
	logic [TL_STRB_W-1:0] wr_mask;
	logic                 err;
	logic                 fire;      // Request consumed, response emitted
	logic [TL_STRB_W-1:0] byte_en;
	logic [TL_DATA_W-1:0] rd_data;

	////////////////////////////////////////////////////////////
	// Address check
	////////////////////////////////////////////////////////////

	// Below base wraps to a huge offset, so one compare covers both ends
	assign offset   = req.address - MEM_BASE_ADDR;
	assign in_range = (offset < WIN_BYTES);
	assign idx      = offset[TL_WORD_SIZE +: MEM_IDX_W]; // Low byte bits dropped

	////////////////////////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////////////////////////

	always_comb begin
		op_ok    = 1'b0;
		is_write = 1'b0;
		is_get   = 1'b0;
		wr_mask  = '0;
		case (req.opcode)
			OP_PUT_FULL: begin
				op_ok    = 1'b1;
				is_write = 1'b1;
				wr_mask  = '1;          // Whole word
			end
			OP_PUT_PARTIAL: begin
				op_ok    = 1'b1;
				is_write = 1'b1;
				wr_mask  = req.mask;    // Selected lanes only
			end
			OP_GET: begin
				op_ok  = 1'b1;
				is_get = 1'b1;
			end
			// Atomics, hints and TL-C codes keep op_ok low and get an error
			default: ;
		endcase
	end

	assign err = !op_ok || !in_range;

	////////////////////////////////////////////////////////////
	// Handshake and memory
	////////////////////////////////////////////////////////////

	// Pass-through stage, stalls only when the response side is full
	assign req_ready = rsp_ready;
	assign rsp_valid = req_valid;
	assign fire      = req_valid && rsp_ready;

	// Write lands on the handshake edge
	assign byte_en = (fire && is_write && !err) ? wr_mask : '0;

	byte_mem mem0 (
		.clk     (clk),
		.rst     (rst),
		.wr_idx  (idx),
		.byte_en (byte_en),
		.wr_data (req.data),
		.rd_idx  (idx),
		.rd_data (rd_data)
	);

	// Response beat
	always_comb begin
		rsp        = '0;        // param and sink stay zero
		rsp.opcode = is_get ? OP_ACCESS_ACK_DATA : OP_ACCESS_ACK;
		rsp.size   = req.size;
		rsp.source = req.source;
		rsp.data   = (is_get && !err) ? rd_data : '0;
		rsp.error  = err;
	end

	// Master must keep param reserved
	a_param_zero: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> (req.param == '0))
		else $error("tl_access_unit: request with nonzero param");

endmodule

// ==== byte_mem.sv ====
// Byte-writable word memory
module byte_mem
	import tl_pkg::*;
	import mem_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	// Write port, one enable per byte lane
	input  mem_idx_t             wr_idx,
	input  logic [TL_STRB_W-1:0] byte_en,
	input  logic [TL_DATA_W-1:0] wr_data,

	// Read port, combinational
	input  mem_idx_t             rd_idx,
	output logic [TL_DATA_W-1:0] rd_data
);

	// Word seen as an array of byte lanes
	typedef logic [TL_STRB_W-1:0][7:0] word_t;

	word_t mem [MEM_DEPTH];
	word_t wr_word;

	assign wr_word = wr_data;       // Split into lanes
	assign rd_data = mem[rd_idx];   // Same-cycle read

	////////////////////////////////////////////////////////////
	// Write with byte merge
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			// Whole window reads back as zero after reset
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;
		end else begin
			for (int b = 0; b < TL_STRB_W; b++) begin
				if (byte_en[b])
					mem[wr_idx][b] <= wr_word[b]; // Other lanes keep old bytes
			end
		end
	end

endmodule

// ==== tl_fifo.sv ====
// Valid/ready channel FIFO
module tl_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 2
) (
	input  logic     clk,
	input  logic     rst,

	// Upstream side
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,

	// Downstream side
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t             buf_q [DEPTH]; // Payload storage
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 push;
	logic                 pop;

	// Circular increment, DEPTH need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign in_ready  = (count != CNT_W'(DEPTH)); // Full blocks upstream
	assign out_valid = (count != '0);
	assign out_data  = buf_q[rd_ptr];            // Head entry

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			buf_q[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle or push and pop together
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Write slot sits on the head entry while full
	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		(count == CNT_W'(DEPTH)) |=> (wr_ptr == $past(wr_ptr)))
		else $error("tl_fifo: transfer in while full");

	// Head beat must not move while the consumer stalls
	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
		else $error("tl_fifo: out_data changed under back-pressure");

endmodule

// ==== mem_pkg.sv ====
// Backing memory layout
package mem_pkg;

	////////////////////////////////////////////////////////////
	// Memory window
	////////////////////////////////////////////////////////////

	localparam int MEM_DEPTH = 512; // 64-bit words

	// Byte address of word 0
	localparam logic [31:0] MEM_BASE_ADDR = 32'h1000_0000;

	// Word index width
	localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

endpackage

// ==== tl_pkg.sv ====
// TileLink UL protocol definitions
package tl_pkg;

	////////////////////////////////////////////////////////////
	// Channel field widths
	////////////////////////////////////////////////////////////

	localparam int TL_ADDR_W    = 32;           // Byte address
	localparam int TL_DATA_W    = 64;           // One beat
	localparam int TL_STRB_W    = TL_DATA_W / 8; // One mask bit per data byte
	localparam int TL_SOURCE_W  = 3;            // Master tag, echoed in D
	localparam int TL_SINK_W    = 3;            // Slave tag, unused in UL
	localparam int TL_OPCODE_W  = 3;
	localparam int TL_PARAM_W   = 3;            // Reserved, always 0
	localparam int TL_SIZE_W    = 3;            // log2 of the bytes moved
	localparam int TL_WORD_SIZE = 3;            // log2(TL_STRB_W)

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	// A channel, standard TileLink codes
	localparam logic [TL_OPCODE_W-1:0] OP_PUT_FULL    = 3'd0;
	localparam logic [TL_OPCODE_W-1:0] OP_PUT_PARTIAL = 3'd1;
	localparam logic [TL_OPCODE_W-1:0] OP_ARITH       = 3'd2; // TL-UH only
	localparam logic [TL_OPCODE_W-1:0] OP_LOGIC       = 3'd3; // TL-UH only
	localparam logic [TL_OPCODE_W-1:0] OP_GET         = 3'd4;
	localparam logic [TL_OPCODE_W-1:0] OP_INTENT      = 3'd5; // TL-UH only

	// D channel
	localparam logic [TL_OPCODE_W-1:0] OP_ACCESS_ACK      = 3'd0; // Dataless ack
	localparam logic [TL_OPCODE_W-1:0] OP_ACCESS_ACK_DATA = 3'd1; // Ack with read data

	////////////////////////////////////////////////////////////
	// Channel beats
	////////////////////////////////////////////////////////////

	// A channel beat, master to slave
	typedef struct packed {
		logic [TL_OPCODE_W-1:0] opcode;
		logic [TL_PARAM_W-1:0]  param;
		logic [TL_ADDR_W-1:0]   address;
		logic [TL_SIZE_W-1:0]   size;
		logic [TL_STRB_W-1:0]   mask;    // Byte lanes for PutPartial
		logic [TL_DATA_W-1:0]   data;
		logic [TL_SOURCE_W-1:0] source;
	} a_req_t;

	// D channel beat, slave to master
	typedef struct packed {
		logic [TL_OPCODE_W-1:0] opcode;
		logic [TL_PARAM_W-1:0]  param;
		logic [TL_SIZE_W-1:0]   size;
		logic [TL_SINK_W-1:0]   sink;
		logic [TL_SOURCE_W-1:0] source;  // Copied from the request
		logic [TL_DATA_W-1:0]   data;
		logic                   error;   // Denied or unsupported
	} d_rsp_t;

endpackage
